// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

    // full bus address and data word
    typedef logic [63:0] xlen_t;
    // ram word, also the width of controller registers
    typedef logic [31:0] word_t;
    // interrupt priority and threshold
    typedef logic [2:0] prio_t;

    // load/store encodings as driven by the processor
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,
        LS_HALF   = 3'd1,
        LS_WORD   = 3'd2,
        LS_DOUBLE = 3'd3,
        LS_BYTE_U = 3'd4,
        LS_HALF_U = 3'd5,
        LS_WORD_U = 3'd6
    } ls_type_t;

    // on-chip ram window
    localparam xlen_t RAM_BASE = 64'h0000_0000_8000_0000;
    localparam int RAM_WORDS = 512;
    typedef logic [$clog2(RAM_WORDS)-1:0] ram_index_t;

    // interrupt controller window and register map
    localparam xlen_t PLIC_BASE = 64'h0000_0000_0C00_0000;
    localparam xlen_t PLIC_PENDING_OFS = 64'h1000;
    localparam xlen_t PLIC_ENABLE_OFS = 64'h2000;
    localparam xlen_t PLIC_CTX_ENABLE_STRIDE = 64'h80;
    localparam xlen_t PLIC_THRESHOLD_OFS = 64'h20_0000;
    localparam xlen_t PLIC_CLAIM_OFS = 64'h20_0004;
    localparam xlen_t PLIC_CTX_STRIDE = 64'h1000;
    localparam xlen_t PLIC_SPAN = 64'h40_0000;
    localparam int PLIC_IDS = 6;

    // id raised by the external source
    localparam int IRQ_ID = 1;

endpackage

// File: src/bus_target_if.sv
interface bus_target_if;

    // request side, driven by the sequencer
    // one-cycle pulses
    logic rd_strb;
    logic wr_strb;
    // address relative to the target base
    soc_bus_pkg::xlen_t offset;
    soc_bus_pkg::ls_type_t ls_type;
    soc_bus_pkg::xlen_t wdata;

    // response side, driven by the target
    // rdata only valid while ack is high
    soc_bus_pkg::xlen_t rdata;
    logic ack;

    modport target (
        input  rd_strb, wr_strb, offset, ls_type, wdata,
        output rdata, ack
    );

    modport initiator (
        output rd_strb, wr_strb, offset, ls_type, wdata,
        input  rdata, ack
    );

endinterface

// File: src/ram_port.sv
module ram_port (
    input logic CLOCK_50,
    input logic KEY0,
    bus_target_if.target bus
);
    import soc_bus_pkg::*;

    // word storage, cleared at configuration
    word_t mem [RAM_WORDS] = '{default: '0};

    // second beat of a double is due
    logic beat;
    // direction of the double in flight
    logic pend_rd;
    logic pend_wr;

    logic is_double;
    logic do_rd;
    logic do_wr;
    ram_index_t idx;
    word_t rd_word;
    word_t shifted;
    xlen_t load_val;
    word_t wr_word;
    word_t lane_data;
    logic [3:0] be;

    assign is_double = (bus.ls_type == LS_DOUBLE);

    // an access happens on a strobe or on the double's second beat
    assign do_rd = bus.rd_strb || (beat && pend_rd);
    assign do_wr = bus.wr_strb || (beat && pend_wr);

    // high word of a double sits at the next index
    assign idx = bus.offset[2 +: $bits(ram_index_t)] + ram_index_t'(beat);

    assign rd_word = mem[idx];
    // move the addressed byte down to lane 0
    assign shifted = rd_word >> {bus.offset[1:0], 3'b000};

    // sign or zero extension by type
    always_comb begin
        case (bus.ls_type)
            LS_BYTE:   load_val = {{56{shifted[7]}}, shifted[7:0]};
            LS_HALF:   load_val = {{48{shifted[15]}}, shifted[15:0]};
            LS_WORD:   load_val = {{32{shifted[31]}}, shifted};
            LS_BYTE_U: load_val = {56'd0, shifted[7:0]};
            LS_HALF_U: load_val = {48'd0, shifted[15:0]};
            default:   load_val = {32'd0, shifted};
        endcase
    end

    // low half on the first beat, high half on the second
    assign wr_word = beat ? bus.wdata[63:32] : bus.wdata[31:0];

    // byte lanes touched by a store
    always_comb begin
        case (bus.ls_type)
            LS_BYTE, LS_BYTE_U: begin
                be = 4'b0001 << bus.offset[1:0];
                lane_data = {4{wr_word[7:0]}};
            end
            LS_HALF, LS_HALF_U: begin
                be = bus.offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wr_word[15:0]}};
            end
            default: begin
                be = 4'b1111;
                lane_data = wr_word;
            end
        endcase
    end

    // beat tracking and ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
            pend_rd <= 1'b0;
            pend_wr <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            beat <= 1'b0;
            if (beat) begin
                // second beat done, answer now
                bus.ack <= 1'b1;
                pend_rd <= 1'b0;
                pend_wr <= 1'b0;
            end else if (bus.rd_strb || bus.wr_strb) begin
                if (is_double) begin
                    beat <= 1'b1;
                    pend_rd <= bus.rd_strb;
                    pend_wr <= bus.wr_strb;
                end else begin
                    bus.ack <= 1'b1;
                end
            end
        end
    end

    // array write and load data
    always_ff @(posedge CLOCK_50) begin
        if (do_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    mem[idx][8*b +: 8] <= lane_data[8*b +: 8];
            end
        end
        if (do_rd) begin
            if (!is_double)
                bus.rdata <= load_val;
            else if (beat)
                bus.rdata[63:32] <= rd_word;
            else
                bus.rdata[31:0] <= rd_word;
        end
    end

endmodule

// File: src/plic_regs.sv
module plic_regs (
    input logic CLOCK_50,
    input logic KEY0,
    bus_target_if.target bus,
    input logic irq_source,
    output logic meip,
    output logic msip
);
    import soc_bus_pkg::*;

    // priority per id, 4 bytes apart from offset 0
    prio_t prio [PLIC_IDS];
    // global pending bitmap
    word_t pending;
    // per context registers
    word_t enable [2];
    prio_t threshold [2];
    word_t claim [2];

    logic prio_sel;
    logic [$clog2(PLIC_IDS)-1:0] prio_id;
    logic pending_sel;
    logic [1:0] enable_sel;
    logic [1:0] threshold_sel;
    logic [1:0] claim_sel;
    xlen_t rd_val;

    // only the source id takes part in the claim
    // priority and threshold are kept for software, no gating
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            if (pending[IRQ_ID] && enable[c][IRQ_ID])
                claim[c] = word_t'(IRQ_ID);
            else
                claim[c] = '0;
        end
    end

    // context 0 is machine external, context 1 goes out as msip
    assign meip = (claim[0] != '0);
    assign msip = (claim[1] != '0);

    // register decode
    assign prio_sel = ((bus.offset >> 2) < xlen_t'(PLIC_IDS));
    assign prio_id = bus.offset[2 +: $clog2(PLIC_IDS)];
    assign pending_sel = (bus.offset == PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            enable_sel[c] = (bus.offset == PLIC_ENABLE_OFS
                + xlen_t'(c) * PLIC_CTX_ENABLE_STRIDE);
            threshold_sel[c] = (bus.offset == PLIC_THRESHOLD_OFS
                + xlen_t'(c) * PLIC_CTX_STRIDE);
            claim_sel[c] = (bus.offset == PLIC_CLAIM_OFS
                + xlen_t'(c) * PLIC_CTX_STRIDE);
        end
    end

    // readback mux, holes read as zero
    always_comb begin
        rd_val = '0;
        if (prio_sel)
            rd_val = xlen_t'(prio[prio_id]);
        if (pending_sel)
            rd_val = xlen_t'(pending);
        for (int c = 0; c < 2; c++) begin
            if (enable_sel[c])
                rd_val = xlen_t'(enable[c]);
            if (threshold_sel[c])
                rd_val = xlen_t'(threshold[c]);
            if (claim_sel[c])
                rd_val = xlen_t'(claim[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < PLIC_IDS; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c] <= '0;
                threshold[c] <= '0;
            end
            pending <= '0;
            bus.ack <= 1'b0;
        end else begin
            // every strobe answered next cycle
            bus.ack <= bus.rd_strb || bus.wr_strb;
            if (bus.wr_strb) begin
                if (prio_sel)
                    prio[prio_id] <= bus.wdata[2:0];
                for (int c = 0; c < 2; c++) begin
                    if (enable_sel[c])
                        enable[c] <= bus.wdata[31:0];
                    if (threshold_sel[c])
                        threshold[c] <= bus.wdata[2:0];
                end
                // claim writes (completion) just ack
            end
            if (bus.rd_strb) begin
                // reading a claim retires that id
                for (int c = 0; c < 2; c++) begin
                    if (claim_sel[c] && claim[c] != '0)
                        pending[claim[c][4:0]] <= 1'b0;
                end
            end
            // a source still high keeps it pending
            if (irq_source)
                pending[IRQ_ID] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.rd_strb)
            bus.rdata <= rd_val;
    end

endmodule

// File: src/bus_sequencer.sv
module bus_sequencer (
    input logic CLOCK_50,
    input logic KEY0,
    input soc_bus_pkg::xlen_t bus_address,
    input soc_bus_pkg::xlen_t bus_write_data,
    input logic bus_read_enable,
    input logic bus_write_enable,
    input soc_bus_pkg::ls_type_t bus_ls_type,
    output soc_bus_pkg::xlen_t bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    bus_target_if.initiator ram,
    bus_target_if.initiator plic
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT_ACK,
        SEQ_RESPOND
    } seq_state_t;

    seq_state_t state;

    // request held for the whole access
    xlen_t req_addr;
    xlen_t req_wdata;
    ls_type_t req_ls;
    logic req_rd;

    logic accept;
    logic ram_hit;
    logic plic_hit;

    // enables outside idle are dropped
    assign accept = (state == SEQ_IDLE) && (bus_read_enable || bus_write_enable);

    // window decode on the held address
    assign ram_hit = (req_addr >= RAM_BASE)
        && (req_addr < RAM_BASE + xlen_t'(RAM_WORDS * 4));
    assign plic_hit = (req_addr >= PLIC_BASE) && (req_addr < PLIC_BASE + PLIC_SPAN);

    // both targets see the same request, only the strobe differs
    assign ram.offset = req_addr - RAM_BASE;
    assign ram.ls_type = req_ls;
    assign ram.wdata = req_wdata;
    assign plic.offset = req_addr - PLIC_BASE;
    assign plic.ls_type = req_ls;
    assign plic.wdata = req_wdata;

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_addr <= bus_address;
            req_wdata <= bus_write_data;
            req_ls <= bus_ls_type;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= SEQ_IDLE;
            req_rd <= 1'b0;
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data <= '0;
            ram.rd_strb <= 1'b0;
            ram.wr_strb <= 1'b0;
            plic.rd_strb <= 1'b0;
            plic.wr_strb <= 1'b0;
        end else begin
            // strobes last one cycle
            ram.rd_strb <= 1'b0;
            ram.wr_strb <= 1'b0;
            plic.rd_strb <= 1'b0;
            plic.wr_strb <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        // read wins if both pulse together
                        req_rd <= bus_read_enable;
                        state <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    if (req_rd)
                        bus_read_done <= 1'b0;
                    else
                        bus_write_done <= 1'b0;
                    if (ram_hit) begin
                        ram.rd_strb <= req_rd;
                        ram.wr_strb <= !req_rd;
                        state <= SEQ_WAIT_ACK;
                    end else if (plic_hit) begin
                        plic.rd_strb <= req_rd;
                        plic.wr_strb <= !req_rd;
                        state <= SEQ_WAIT_ACK;
                    end else begin
                        // nothing mapped here, finish locally
                        state <= SEQ_RESPOND;
                    end
                end
                SEQ_WAIT_ACK: begin
                    if (ram.ack || plic.ack) begin
                        if (req_rd) begin
                            bus_read_data <= ram.ack ? ram.rdata : plic.rdata;
                            bus_read_done <= 1'b1;
                        end else begin
                            bus_write_done <= 1'b1;
                        end
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    // unmapped read returns zero, write is dropped
                    if (req_rd) begin
                        bus_read_data <= '0;
                        bus_read_done <= 1'b1;
                    end else begin
                        bus_write_done <= 1'b1;
                    end
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/soc_bus.sv
module soc_bus (
    input logic CLOCK_50,
    input logic KEY0,
    input soc_bus_pkg::xlen_t bus_address,
    input soc_bus_pkg::xlen_t bus_write_data,
    input logic bus_read_enable,
    input logic bus_write_enable,
    input soc_bus_pkg::ls_type_t bus_ls_type,
    input logic irq_source,
    output soc_bus_pkg::xlen_t bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    output logic meip,
    output logic msip
);

    // one link per target
    bus_target_if ram_link ();
    bus_target_if plic_link ();

    // decode and handshake with the processor side
    bus_sequencer u_bus_sequencer (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram              (ram_link.initiator),
        .plic             (plic_link.initiator)
    );

    ram_port u_ram_port (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_link.target)
    );

    // interrupt lines leave at the top
    plic_regs u_plic_regs (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus        (plic_link.target),
        .irq_source (irq_source),
        .meip       (meip),
        .msip       (msip)
    );

endmodule

// File: test/tb_soc_bus.sv
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_bus_pkg::*;

    // seven fields per vector line
    localparam int FIELDS = 7;
    localparam int MAX_VECTORS = 64;
    localparam int VEC_WORDS = FIELDS * MAX_VECTORS;
    // cycles allowed for each edge of done
    localparam int DONE_LIMIT = 50;

    logic CLOCK_50 = 1'b0;
    logic KEY0;
    xlen_t bus_address;
    xlen_t bus_write_data;
    logic bus_read_enable;
    logic bus_write_enable;
    ls_type_t bus_ls_type;
    logic irq_source;
    xlen_t bus_read_data;
    logic bus_read_done;
    logic bus_write_done;
    logic meip;
    logic msip;

    logic [63:0] vec_mem [VEC_WORDS];
    integer seed;

    always #5 CLOCK_50 = ~CLOCK_50;

    soc_bus u_soc_bus (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .irq_source       (irq_source),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip             (meip),
        .msip             (msip)
    );

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    // counts falling edges from the request edge until done falls, then rises
    task automatic wait_done(input logic is_read, output int low_at, output int high_at);
        int cnt;
        cnt = 0;
        do begin
            @(negedge CLOCK_50);
            cnt++;
        end while ((is_read ? bus_read_done : bus_write_done) && cnt < DONE_LIMIT);
        if (is_read ? bus_read_done : bus_write_done)
            fail_run("timeout: done level never went low");
        low_at = cnt;
        do begin
            @(negedge CLOCK_50);
            cnt++;
        end while (!(is_read ? bus_read_done : bus_write_done) && cnt < 2 * DONE_LIMIT);
        if (!(is_read ? bus_read_done : bus_write_done))
            fail_run("timeout: done level never returned high");
        high_at = cnt;
    endtask

    // one-cycle enable, request held until done
    task automatic run_access(input logic write, input ls_type_t ls, input xlen_t addr,
                              input xlen_t wdata, output int low_at, output int high_at);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_write_data <= wdata;
        bus_ls_type <= ls;
        bus_read_enable <= !write;
        bus_write_enable <= write;
        // request is taken on this edge
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        bus_write_enable <= 1'b0;
        wait_done(!write, low_at, high_at);
    endtask

    task automatic drive_irq(input logic level);
        @(posedge CLOCK_50);
        irq_source <= level;
        // pending bit follows one edge later
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
    endtask

    initial begin
        int base;
        int idx;
        int low_at;
        int high_at;
        int gap;
        logic finished;
        logic [3:0] op;
        ls_type_t ls;
        xlen_t addr;
        xlen_t wdata;
        xlen_t exp_data;

        seed = 38226;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        bus_ls_type = LS_BYTE;
        irq_source = 1'b0;
        $readmemh("test/soc_bus_vectors.txt", vec_mem);

        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(posedge CLOCK_50);

        base = 0;
        idx = 0;
        finished = 1'b0;
        while (!finished) begin
            if (base + FIELDS > VEC_WORDS)
                fail_run("vector file has no end marker");
            op = vec_mem[base][3:0];
            ls = ls_type_t'(vec_mem[base + 1][2:0]);
            addr = vec_mem[base + 2];
            wdata = vec_mem[base + 3];
            exp_data = vec_mem[base + 4];
            if (op === 4'hf) begin
                finished = 1'b1;
            end else begin
                case (op)
                    4'h0, 4'h4: begin
                        run_access(1'b0, ls, addr, '0, low_at, high_at);
                        check_value($sformatf("vector %0d read data", idx),
                                    exp_data, bus_read_data);
                        // ram word read: low after E+1, high after E+3
                        if (op == 4'h4) begin
                            check_value($sformatf("vector %0d done fall", idx),
                                        64'd2, xlen_t'(low_at));
                            check_value($sformatf("vector %0d done rise", idx),
                                        64'd4, xlen_t'(high_at));
                        end
                    end
                    4'h1: run_access(1'b1, ls, addr, wdata, low_at, high_at);
                    4'h2: drive_irq(1'b1);
                    4'h3: drive_irq(1'b0);
                    default: fail_run($sformatf("vector %0d has unknown operation", idx));
                endcase
                check_value($sformatf("vector %0d meip", idx),
                            xlen_t'(vec_mem[base + 5][0]), xlen_t'(meip));
                check_value($sformatf("vector %0d msip", idx),
                            xlen_t'(vec_mem[base + 6][0]), xlen_t'(msip));
                // idle gap, no effect on results
                gap = $random(seed) & 3;
                repeat (gap) @(posedge CLOCK_50);
            end
            base += FIELDS;
            idx++;
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: soc_bus.f
src/soc_bus_pkg.sv
src/bus_target_if.sv
src/ram_port.sv
src/plic_regs.sv
src/bus_sequencer.sv
src/soc_bus.sv
test/tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the soc_bus testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_soc_bus -o tb_soc_bus -f soc_bus.f \
    && ./obj_dir/tb_soc_bus | tee /dev/stderr | grep -qF "TESTBENCH PASSED" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

// File: test/soc_bus_vectors.txt
// op: 0 read, 1 write, 2 irq high, 3 irq low, 4 read with done timing, f end
// columns: op ls_type address write_data expected_read expected_meip expected_msip
1 2 80000000 12345678 0 0 0
0 2 80000000 0 12345678 0 0
1 2 80000004 89abcdef 0 0 0
0 2 80000004 0 ffffffff89abcdef 0 0
0 6 80000004 0 89abcdef 0 0
1 3 80000008 0123456789abcdef 0 0 0
0 3 80000008 0 0123456789abcdef 0 0
0 6 8000000c 0 01234567 0 0
1 0 80000001 aa 0 0 0
0 6 80000000 0 1234aa78 0 0
1 1 80000002 8001 0 0 0
0 0 80000001 0 ffffffffffffffaa 0 0
0 4 80000001 0 aa 0 0
0 1 80000002 0 ffffffffffff8001 0 0
0 5 80000002 0 8001 0 0
0 1 80000000 0 ffffffffffffaa78 0 0
0 0 80000000 0 78 0 0
0 6 80000000 0 8001aa78 0 0
0 2 0c001000 0 0 0 0
1 2 0c000004 5 0 0 0
0 2 0c000004 0 5 0 0
1 2 0c00000c 6 0 0 0
0 2 0c00000c 0 6 0 0
1 2 0c002000 2 0 0 0
0 2 0c002000 0 2 0 0
1 2 0c002080 3c 0 0 0
0 2 0c002080 0 3c 0 0
1 2 0c200000 3 0 0 0
0 2 0c200000 0 3 0 0
1 2 0c201000 6 0 0 0
0 2 0c201000 0 6 0 0
2 0 0 0 0 1 0
0 2 0c001000 0 2 1 0
3 0 0 0 0 1 0
0 2 0c200004 0 1 0 0
0 2 0c200004 0 0 0 0
0 2 10000000 0 0 0 0
1 2 10000000 ffff 0 0 0
1 2 80000800 deadbeef 0 0 0
0 6 80000000 0 8001aa78 0 0
0 2 0c000004 0 5 0 0
0 2 0c002000 0 2 0 0
4 6 80000008 0 89abcdef 0 0
f 0 0 0 0 0 0
